// File: source/obi_support_pkg.sv
/*
  Shared types and constants for the OBI bus support blocks.
  Holds the bus handshake, request attribute, FIFO tag and status
  structs, plus the core's next-PC source encoding used by the trap
  detector. Compile this first; modules import it in their bodies.
*/

`default_nettype none

package obi_support_pkg;

  // ----------------------------------------
  // bus limits
  // ----------------------------------------

  // transactions granted but not yet answered on one bus
  localparam int unsigned OBI_MAX_OUTSTANDING = 3;
  localparam int unsigned OBI_CNT_W           = 2;

  // ----------------------------------------
  // bus side structs
  // ----------------------------------------

  // raw handshake, gntpar should always be the inverse of gnt
  typedef struct packed {
    logic req;
    logic gnt;
    logic gntpar;
    logic rvalid;
  } obi_bus_t;

  typedef struct packed {
    logic we;
    logic integrity;
  } obi_attr_t;

  // one FIFO entry per granted request
  typedef struct packed {
    obi_attr_t attr;
    logic      gnt_err;
  } obi_tag_t;

  typedef struct packed {
    logic     valid;
    obi_tag_t tag;
  } obi_resp_info_t;

  typedef struct packed {
    logic                 addr_ph_cont;
    logic [OBI_CNT_W-1:0] outstanding;
  } obi_phase_t;

  // ----------------------------------------
  // core control
  // ----------------------------------------

  typedef enum logic [2:0] {
    PC_BOOT     = 3'd0,
    PC_JUMP     = 3'd1,
    PC_BRANCH   = 3'd2,
    PC_MRET     = 3'd3,
    PC_TRAP_EXC = 3'd4,
    PC_TRAP_DBE = 3'd5,
    PC_TRAP_IRQ = 3'd6,
    PC_WB_PLUS4 = 3'd7
  } pc_mux_e;

  typedef struct packed {
    logic    pc_set;
    pc_mux_e pc_mux;
  } ctrl_pc_t;

endpackage

`default_nettype wire

// File: source/obi_phase_monitor.sv
/*
  Phase status for one OBI bus.
  Flags an address phase that lasts more than one cycle and counts the
  transactions that were granted but not answered yet. The counter
  shows that no response ever comes ahead of its address phase.
*/

`default_nettype none

module obi_phase_monitor (
  input  logic                         clk_i,
  input  logic                         rst_ni,
  input  obi_support_pkg::obi_bus_t    bus_i,
  output obi_support_pkg::obi_phase_t  phase_o
);

  import obi_support_pkg::*;

  logic                 addr_done;
  logic                 resp_done;
  logic                 addr_ph_cont_q;
  logic [OBI_CNT_W-1:0] outstanding_q;

  // rready is tied high, so any rvalid ends a response phase
  assign addr_done = bus_i.req && bus_i.gnt;
  assign resp_done = bus_i.rvalid;

  // high in the cycle after a request that was not granted
  always_ff @(posedge clk_i or negedge rst_ni) begin
    if (!rst_ni) begin
      addr_ph_cont_q <= 1'b0;
    end else begin
      addr_ph_cont_q <= bus_i.req && !bus_i.gnt;
    end
  end

  // saturating count, unchanged when a grant and a response coincide
  always_ff @(posedge clk_i or negedge rst_ni) begin
    if (!rst_ni) begin
      outstanding_q <= '0;
    end else if (addr_done && !resp_done && (outstanding_q < OBI_MAX_OUTSTANDING)) begin
      outstanding_q <= outstanding_q + 1'b1;
    end else if (!addr_done && resp_done && (outstanding_q != '0)) begin
      outstanding_q <= outstanding_q - 1'b1;
    end
  end

  assign phase_o.addr_ph_cont = addr_ph_cont_q;
  assign phase_o.outstanding  = outstanding_q;

endmodule

`default_nettype wire

// File: source/obi_resp_tracker.sv
/*
  In-order queue that carries the tag of each granted request to its
  response. Push on address completion, pop on rvalid. The head tag is
  shown in the same cycle as the pop; an empty queue gives a zero tag.
  A push into a full queue without a pop is lost.
*/

`default_nettype none

module obi_resp_tracker (
  input  logic                            clk_i,
  input  logic                            rst_ni,
  input  logic                            push_i,
  input  obi_support_pkg::obi_tag_t       tag_i,
  input  logic                            pop_i,
  output obi_support_pkg::obi_resp_info_t resp_o
);

  import obi_support_pkg::*;

  obi_tag_t             mem_q [OBI_MAX_OUTSTANDING];
  logic [OBI_CNT_W-1:0] wr_ptr_q;
  logic [OBI_CNT_W-1:0] rd_ptr_q;
  logic [OBI_CNT_W-1:0] count_q;
  logic                 not_empty;
  logic                 do_pop;
  logic                 do_push;

  // pointers wrap at the queue depth, which need not be a power of two
  function automatic logic [OBI_CNT_W-1:0] ptr_next(input logic [OBI_CNT_W-1:0] ptr);
    logic [OBI_CNT_W-1:0] last;
    last = OBI_CNT_W'(OBI_MAX_OUTSTANDING - 1);
    if (ptr == last) begin
      return '0;
    end
    return ptr + 1'b1;
  endfunction

  assign not_empty = (count_q != '0);
  assign do_pop    = pop_i && not_empty;
  // a pop in the same cycle frees the slot for a push into a full queue
  assign do_push   = push_i && ((count_q < OBI_MAX_OUTSTANDING) || do_pop);

  always_ff @(posedge clk_i) begin
    if (do_push) begin
      mem_q[wr_ptr_q] <= tag_i;
    end
  end

  always_ff @(posedge clk_i or negedge rst_ni) begin
    if (!rst_ni) begin
      wr_ptr_q <= '0;
      rd_ptr_q <= '0;
      count_q  <= '0;
    end else begin
      if (do_push) begin
        wr_ptr_q <= ptr_next(wr_ptr_q);
      end
      if (do_pop) begin
        rd_ptr_q <= ptr_next(rd_ptr_q);
      end
      case ({do_push, do_pop})
        2'b10:   count_q <= count_q + 1'b1;
        2'b01:   count_q <= count_q - 1'b1;
        default: count_q <= count_q;
      endcase
    end
  end

  // zero latency answer
  assign resp_o.valid = pop_i;
  assign resp_o.tag   = do_pop ? mem_q[rd_ptr_q] : '0;

endmodule

`default_nettype wire

// File: source/obi_bus_monitor.sv
/*
  Full monitor for one OBI bus.
  Checks grant parity over the whole address phase, tags each granted
  request with its attributes and parity result, and hands the tag back
  with the matching response. Also reports the phase status.
*/

`default_nettype none

module obi_bus_monitor (
  input  logic                            clk_i,
  input  logic                            rst_ni,
  input  obi_support_pkg::obi_bus_t       bus_i,
  input  obi_support_pkg::obi_attr_t      attr_i,
  output obi_support_pkg::obi_phase_t     phase_o,
  output obi_support_pkg::obi_resp_info_t resp_o
);

  import obi_support_pkg::*;

  logic     req_err;
  logic     err_sticky_q;
  logic     addr_done;
  obi_tag_t req_tag;

  // ----------------------------------------
  // grant parity check
  // ----------------------------------------

  // gnt equal to gntpar is a parity error, now or earlier in this phase
  assign req_err = bus_i.req && ((bus_i.gnt == bus_i.gntpar) || err_sticky_q);

  // remember an error seen while the request waits for its grant
  always_ff @(posedge clk_i or negedge rst_ni) begin
    if (!rst_ni) begin
      err_sticky_q <= 1'b0;
    end else if (bus_i.req && !bus_i.gnt) begin
      err_sticky_q <= req_err;
    end else begin
      err_sticky_q <= 1'b0;
    end
  end

  // ----------------------------------------
  // tag and tracking
  // ----------------------------------------

  assign addr_done       = bus_i.req && bus_i.gnt;
  assign req_tag.attr    = attr_i;
  assign req_tag.gnt_err = req_err;

  obi_phase_monitor phase_mon_i (
    .clk_i   (clk_i),
    .rst_ni  (rst_ni),
    .bus_i   (bus_i),
    .phase_o (phase_o)
  );

  obi_resp_tracker resp_trk_i (
    .clk_i  (clk_i),
    .rst_ni (rst_ni),
    .push_i (addr_done),
    .tag_i  (req_tag),
    .pop_i  (bus_i.rvalid),
    .resp_o (resp_o)
  );

endmodule

`default_nettype wire

// File: source/trap_req_detector.sv
/*
  Flags a data bus request that follows a granted data request once a
  trap has been taken and before the next instruction retires. Used to
  check that a multi-op instruction stops issuing after an exception.
*/

`default_nettype none

module trap_req_detector (
  input  logic                        clk_i,
  input  logic                        rst_ni,
  input  obi_support_pkg::ctrl_pc_t   ctrl_i,
  input  logic                        retire_i,
  input  obi_support_pkg::obi_bus_t   data_bus_i,
  output logic                        req_after_trap_o
);

  import obi_support_pkg::*;

  logic trap_taken;
  logic trap_active_q;
  logic data_gnt_q;
  logic req_after_gnt;

  // only exceptions and debug entry count, interrupts do not
  assign trap_taken = ctrl_i.pc_set &&
                      ((ctrl_i.pc_mux == PC_TRAP_EXC) || (ctrl_i.pc_mux == PC_TRAP_DBE));

  assign req_after_gnt = data_bus_i.req && data_gnt_q;

  always_ff @(posedge clk_i or negedge rst_ni) begin
    if (!rst_ni) begin
      data_gnt_q <= 1'b0;
    end else begin
      data_gnt_q <= data_bus_i.gnt;
    end
  end

  // a trap wins over a retirement in the same cycle
  always_ff @(posedge clk_i or negedge rst_ni) begin
    if (!rst_ni) begin
      trap_active_q    <= 1'b0;
      req_after_trap_o <= 1'b0;
    end else if (trap_taken) begin
      trap_active_q <= 1'b1;
      if (req_after_gnt) begin
        req_after_trap_o <= 1'b1;
      end
    end else if (retire_i) begin
      trap_active_q    <= 1'b0;
      req_after_trap_o <= 1'b0;
    end else if (trap_active_q && req_after_gnt) begin
      req_after_trap_o <= 1'b1;
    end
  end

endmodule

`default_nettype wire

// File: source/obi_support_logic.sv
/*
  Top level of the OBI support logic.
  One bus monitor each for instruction fetch and data, plus the
  trap request detector on the data bus. Observes only; nothing here
  drives back into the buses.
*/

`default_nettype none

module obi_support_logic (
  input  logic                            clk_i,
  input  logic                            rst_ni,

  // raw buses and request attributes
  input  obi_support_pkg::obi_bus_t       instr_bus_i,
  input  obi_support_pkg::obi_bus_t       data_bus_i,
  input  obi_support_pkg::obi_attr_t      instr_attr_i,
  input  obi_support_pkg::obi_attr_t      data_attr_i,

  // core control and retirement
  input  obi_support_pkg::ctrl_pc_t       ctrl_i,
  input  logic                            retire_i,

  // derived status
  output obi_support_pkg::obi_phase_t     instr_phase_o,
  output obi_support_pkg::obi_phase_t     data_phase_o,
  output obi_support_pkg::obi_resp_info_t instr_resp_o,
  output obi_support_pkg::obi_resp_info_t data_resp_o,
  output logic                            req_after_trap_o
);

  // ----------------------------------------
  // bus monitors
  // ----------------------------------------

  obi_bus_monitor instr_mon_i (
    .clk_i   (clk_i),
    .rst_ni  (rst_ni),
    .bus_i   (instr_bus_i),
    .attr_i  (instr_attr_i),
    .phase_o (instr_phase_o),
    .resp_o  (instr_resp_o)
  );

  obi_bus_monitor data_mon_i (
    .clk_i   (clk_i),
    .rst_ni  (rst_ni),
    .bus_i   (data_bus_i),
    .attr_i  (data_attr_i),
    .phase_o (data_phase_o),
    .resp_o  (data_resp_o)
  );

  // data requests after a trap
  trap_req_detector trap_det_i (
    .clk_i            (clk_i),
    .rst_ni           (rst_ni),
    .ctrl_i           (ctrl_i),
    .retire_i         (retire_i),
    .data_bus_i       (data_bus_i),
    .req_after_trap_o (req_after_trap_o)
  );

endmodule

`default_nettype wire

// File: verif/obi_support_properties.sv
/*
  Concurrent checks on the OBI support logic, bound to its top level.
  Covers responses against the outstanding count, grants into a full
  response queue, the stall flag out of reset and the zero latency
  response valid.
*/

`default_nettype none

module obi_support_properties (
  input logic                            clk_i,
  input logic                            rst_ni,
  input obi_support_pkg::obi_bus_t       instr_bus_i,
  input obi_support_pkg::obi_bus_t       data_bus_i,
  input obi_support_pkg::obi_phase_t     instr_phase_o,
  input obi_support_pkg::obi_phase_t     data_phase_o,
  input obi_support_pkg::obi_resp_info_t instr_resp_o,
  input obi_support_pkg::obi_resp_info_t data_resp_o
);

  import obi_support_pkg::*;

  // number of failed checks, read by the testbench at the end
  int unsigned fail_cnt = 0;

  // a response always needs a granted request ahead of it
  instr_rvalid_a: assert property (@(posedge clk_i) disable iff (!rst_ni)
    instr_bus_i.rvalid |-> (instr_phase_o.outstanding != '0))
    else begin
      fail_cnt++;
      $error("instr rvalid with no outstanding request");
    end
  data_rvalid_a: assert property (@(posedge clk_i) disable iff (!rst_ni)
    data_bus_i.rvalid |-> (data_phase_o.outstanding != '0))
    else begin
      fail_cnt++;
      $error("data rvalid with no outstanding request");
    end

  // a grant at the limit would be dropped unless a response frees a slot
  instr_limit_a: assert property (@(posedge clk_i) disable iff (!rst_ni)
    ((instr_phase_o.outstanding == OBI_MAX_OUTSTANDING) && instr_bus_i.req &&
     instr_bus_i.gnt) |-> instr_bus_i.rvalid)
    else begin
      fail_cnt++;
      $error("instr grant beyond the outstanding limit");
    end
  data_limit_a: assert property (@(posedge clk_i) disable iff (!rst_ni)
    ((data_phase_o.outstanding == OBI_MAX_OUTSTANDING) && data_bus_i.req &&
     data_bus_i.gnt) |-> data_bus_i.rvalid)
    else begin
      fail_cnt++;
      $error("data grant beyond the outstanding limit");
    end

  reset_cont_a: assert property (@(posedge clk_i)
    $rose(rst_ni) |-> (!instr_phase_o.addr_ph_cont && !data_phase_o.addr_ph_cont))
    else begin
      fail_cnt++;
      $error("addr_ph_cont set right after reset");
    end

  // answer comes in the rvalid cycle itself
  resp_valid_a: assert property (@(posedge clk_i) disable iff (!rst_ni)
    (instr_resp_o.valid == instr_bus_i.rvalid) && (data_resp_o.valid == data_bus_i.rvalid))
    else begin
      fail_cnt++;
      $error("response valid differs from rvalid");
    end

endmodule

bind obi_support_logic obi_support_properties props_i (.*);

`default_nettype wire

// File: verif/obi_support_tb.sv
/*
  Testbench for the OBI support logic.
  Applies a table of bus transactions with stalls, parity errors and
  overlapping responses, checks every cycle against a model of the
  handshake rules, then runs trap sequences on the data bus.
*/

`default_nettype none

module obi_support_tb;

  import obi_support_pkg::*;

  typedef struct packed {
    logic       bus;       // 0 instr, 1 data
    obi_attr_t  attr;
    logic [1:0] err_mode;  // 0 none, 1 at grant, 2 in first stall cycle
    logic [3:0] stall;
    logic [3:0] delay;
  } row_t;

  localparam int NUM_ROWS = 16;

  logic           clk_i;
  logic           rst_ni;
  obi_bus_t       bus_d [2];
  obi_attr_t      attr_d [2];
  ctrl_pc_t       ctrl_d;
  logic           retire_d;
  obi_phase_t     phase [2];
  obi_resp_info_t resp [2];
  logic           req_after_trap;

  row_t     tbl [NUM_ROWS];
  obi_tag_t instr_exp [$];
  obi_tag_t data_exp [$];
  int       instr_due [$];
  int       data_due [$];
  int       last_due [2];
  logic     stall_prev [2];
  int       cnt_model [2];
  int       errs;
  int       test_errs;
  int       n_pass;
  int       n_fail;
  integer   seed;
  integer   rnd;

  obi_support_logic dut_i (
    .clk_i            (clk_i),
    .rst_ni           (rst_ni),
    .instr_bus_i      (bus_d[0]),
    .data_bus_i       (bus_d[1]),
    .instr_attr_i     (attr_d[0]),
    .data_attr_i      (attr_d[1]),
    .ctrl_i           (ctrl_d),
    .retire_i         (retire_d),
    .instr_phase_o    (phase[0]),
    .data_phase_o     (phase[1]),
    .instr_resp_o     (resp[0]),
    .data_resp_o      (resp[1]),
    .req_after_trap_o (req_after_trap)
  );

  initial begin
    clk_i = 1'b0;
    forever #5 clk_i = ~clk_i;
  end

  function automatic int cycle_now();
    return int'($time / 10);
  endfunction

  task automatic report_mismatch(input string msg);
    $display("Mismatch at %0t: %s", $time, msg);
    test_errs++;
  endtask

  task automatic finish_test(input string name);
    if (test_errs == 0) begin
      $display("test %s: pass", name);
      n_pass++;
    end else begin
      $display("test %s: fail with %0d errors", name, test_errs);
      n_fail++;
    end
    errs += test_errs;
    test_errs = 0;
  endtask

  // ----------------------------------------
  // bus driver
  // ----------------------------------------

  // address phase of one row; the response is scheduled in request order
  task automatic issue(input row_t r);
    int       b;
    int       s;
    int       due;
    obi_tag_t tag;
    b = r.bus;
    for (s = 0; s < r.stall; s++) begin
      bus_d[b].req    <= 1'b1;
      bus_d[b].gnt    <= 1'b0;
      bus_d[b].gntpar <= !((r.err_mode == 2'd2) && (s == 0));
      attr_d[b]       <= r.attr;
      @(posedge clk_i);
    end
    bus_d[b].req    <= 1'b1;
    bus_d[b].gnt    <= 1'b1;
    bus_d[b].gntpar <= (r.err_mode == 2'd1);
    attr_d[b]       <= r.attr;
    tag.attr    = r.attr;
    tag.gnt_err = (r.err_mode != 2'd0);
    due = cycle_now() + r.delay;
    if (due <= last_due[b]) begin
      due = last_due[b] + 1;
    end
    last_due[b] = due;
    if (b == 0) begin
      instr_exp.push_back(tag);
      instr_due.push_back(due);
    end else begin
      data_exp.push_back(tag);
      data_due.push_back(due);
    end
    @(posedge clk_i);
    bus_d[b].req    <= 1'b0;
    bus_d[b].gnt    <= 1'b0;
    bus_d[b].gntpar <= 1'b1;
  endtask

  // rvalid goes high in the cycle a response falls due
  initial begin
    forever begin
      @(posedge clk_i);
      if ((instr_due.size() > 0) && (instr_due[0] == cycle_now())) begin
        bus_d[0].rvalid <= 1'b1;
        void'(instr_due.pop_front());
      end else begin
        bus_d[0].rvalid <= 1'b0;
      end
      if ((data_due.size() > 0) && (data_due[0] == cycle_now())) begin
        bus_d[1].rvalid <= 1'b1;
        void'(data_due.pop_front());
      end else begin
        bus_d[1].rvalid <= 1'b0;
      end
    end
  end

  // ----------------------------------------
  // cycle checker
  // ----------------------------------------

  task automatic check_bus(input int b);
    obi_tag_t exp_tag;
    exp_tag = '0;
    assert (phase[b].addr_ph_cont == stall_prev[b])
      else report_mismatch($sformatf("bus %0d addr_ph_cont %0b, expected %0b",
                                     b, phase[b].addr_ph_cont, stall_prev[b]));
    assert (phase[b].outstanding == cnt_model[b])
      else report_mismatch($sformatf("bus %0d outstanding %0d, expected %0d",
                                     b, phase[b].outstanding, cnt_model[b]));
    if (bus_d[b].rvalid) begin
      if ((b == 0) && (instr_exp.size() > 0)) begin
        exp_tag = instr_exp.pop_front();
      end else if ((b == 1) && (data_exp.size() > 0)) begin
        exp_tag = data_exp.pop_front();
      end else begin
        $display("Bus %0d gave a response with no request waiting at %0t", b, $time);
        test_errs++;
      end
      assert (resp[b].valid && (resp[b].tag == exp_tag))
        else report_mismatch($sformatf("bus %0d response tag %b, expected %b",
                                       b, resp[b].tag, exp_tag));
    end else begin
      assert (!resp[b].valid) else report_mismatch("response valid without rvalid");
    end
    stall_prev[b] = bus_d[b].req && !bus_d[b].gnt;
    if (bus_d[b].req && bus_d[b].gnt && !bus_d[b].rvalid) begin
      cnt_model[b]++;
    end else if (!(bus_d[b].req && bus_d[b].gnt) && bus_d[b].rvalid) begin
      cnt_model[b]--;
    end
  endtask

  initial begin
    forever begin
      @(negedge clk_i);
      if (rst_ni) begin
        check_bus(0);
        check_bus(1);
      end
    end
  end

  // wait for both buses to answer everything, ends on a rising edge
  task automatic wait_idle();
    int t;
    t = 0;
    while (((instr_exp.size() + data_exp.size()) != 0) && (t < 100)) begin
      @(posedge clk_i);
      t++;
    end
    if ((instr_exp.size() + data_exp.size()) != 0) begin
      $display("Timeout: responses still missing after 100 cycles at %0t", $time);
      test_errs++;
    end
    @(negedge clk_i);
    assert ((phase[0].outstanding == '0) && (phase[1].outstanding == '0))
      else report_mismatch("outstanding not back to zero after burst");
    @(posedge clk_i);
  endtask

  // trap or jump, then a granted data request and a stalled one
  task automatic trap_case(input pc_mux_e mux, input logic exp_flag);
    row_t r;
    r = '{1'b1, 2'b01, 2'd0, 4'd0, 4'd2};
    ctrl_d <= '{pc_set: 1'b1, pc_mux: mux};
    @(posedge clk_i);
    ctrl_d <= '0;
    issue(r);
    r.stall = 4'd1;
    issue(r);
    @(negedge clk_i);
    assert (req_after_trap == exp_flag)
      else report_mismatch($sformatf("req_after_trap_o %0b after %s, expected %0b",
                                     req_after_trap, mux.name(), exp_flag));
    @(posedge clk_i);
    retire_d <= 1'b1;
    @(posedge clk_i);
    retire_d <= 1'b0;
    @(negedge clk_i);
    assert (!req_after_trap) else report_mismatch("req_after_trap_o still set after retire");
    wait_idle();
  endtask

  // ----------------------------------------
  // main sequence
  // ----------------------------------------

  initial begin
    seed      = 32'h15ee;
    errs      = 0;
    test_errs = 0;
    n_pass    = 0;
    n_fail    = 0;
    rst_ni    = 1'b0;
    ctrl_d    = '0;
    retire_d  = 1'b0;
    for (int b = 0; b < 2; b++) begin
      bus_d[b]      = '{req: 1'b0, gnt: 1'b0, gntpar: 1'b1, rvalid: 1'b0};
      attr_d[b]     = '0;
      last_due[b]   = 0;
      stall_prev[b] = 1'b0;
      cnt_model[b]  = 0;
    end

    // rows 4..7 and 10..12 overlap up to three responses
    tbl[0]  = '{1'b0, 2'b00, 2'd0, 4'd0, 4'd1};
    tbl[1]  = '{1'b0, 2'b01, 2'd0, 4'd2, 4'd2};
    tbl[2]  = '{1'b0, 2'b10, 2'd1, 4'd0, 4'd1};
    tbl[3]  = '{1'b0, 2'b11, 2'd2, 4'd2, 4'd3};
    tbl[4]  = '{1'b0, 2'b01, 2'd0, 4'd0, 4'd3};
    tbl[5]  = '{1'b0, 2'b10, 2'd0, 4'd0, 4'd3};
    tbl[6]  = '{1'b0, 2'b11, 2'd0, 4'd0, 4'd3};
    tbl[7]  = '{1'b0, 2'b00, 2'd1, 4'd0, 4'd3};
    tbl[8]  = '{1'b1, 2'b10, 2'd0, 4'd0, 4'd2};
    tbl[9]  = '{1'b1, 2'b01, 2'd2, 4'd1, 4'd1};
    tbl[10] = '{1'b1, 2'b11, 2'd0, 4'd0, 4'd3};
    tbl[11] = '{1'b1, 2'b00, 2'd0, 4'd0, 4'd3};
    tbl[12] = '{1'b1, 2'b10, 2'd0, 4'd0, 4'd3};
    for (int i = 13; i < NUM_ROWS; i++) begin
      rnd    = $random(seed);
      tbl[i] = '{i[0], rnd[1:0], 2'd0, 4'd0, 4'd2};
    end

    repeat (2) @(posedge clk_i);
    rst_ni <= 1'b1;
    @(negedge clk_i);
    assert ((phase[0] == '0) && (phase[1] == '0) && !resp[0].valid && !resp[1].valid &&
            !req_after_trap)
      else report_mismatch("outputs not zero after reset");
    finish_test("reset values");

    @(posedge clk_i);
    for (int i = 0; i < NUM_ROWS; i++) begin
      issue(tbl[i]);
    end
    wait_idle();
    finish_test("transaction table");

    trap_case(PC_JUMP, 1'b0);
    trap_case(PC_TRAP_EXC, 1'b1);
    trap_case(PC_TRAP_DBE, 1'b1);
    finish_test("trap request detector");

    errs += dut_i.props_i.fail_cnt;
    $display("%0d tests passed, %0d failed, %0d errors", n_pass, n_fail, errs);
    if (errs == 0) begin
      $display("ALL TESTS PASSED");
    end else begin
      $display("SOME TESTS FAILED");
    end
    $finish;
  end

endmodule

`default_nettype wire

// File: obi_support_logic.f
source/obi_support_pkg.sv
source/obi_phase_monitor.sv
source/obi_resp_tracker.sv
source/obi_bus_monitor.sv
source/trap_req_detector.sv
source/obi_support_logic.sv
verif/obi_support_properties.sv
verif/obi_support_tb.sv
